// File: design/xfer_pkg.sv
`default_nettype none

package xfer_pkg;

	// **********************************************************************
	// Data widths
	// **********************************************************************
	typedef logic [31:0] word_t;
	typedef logic [7:0]  key_t;
	typedef logic [5:0]  level_t;
	typedef logic [4:0]  addr_t;

	// Entries per FIFO, a power of two from 2 to 32
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// **********************************************************************
	// Register byte offsets
	// **********************************************************************
	localparam addr_t REG_CMD     = 5'h00;
	localparam addr_t REG_STATUS  = 5'h04;
	localparam addr_t REG_CONFIG  = 5'h08;
	localparam addr_t REG_TXDATA  = 5'h0C;
	localparam addr_t REG_RXDATA  = 5'h10;
	localparam addr_t REG_RXLEVEL = 5'h14;

	// Transfer controller states
	typedef enum logic [1:0] {IDLE, MOVE, DONE} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/word_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module word_fifo import xfer_pkg::*;
(
	input  wire    rvx_port_15,
	input  wire    rvx_port_16,

	input  wire    push,
	input  word_t  wdata,
	input  wire    pop,

	output word_t  rdata,
	output logic   empty,
	output logic   full,
	output level_t level
);

	word_t                 mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic                  do_push;
	logic                  do_pop;

	// Requests past the limits are dropped here as well
	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;

	assign empty = (level == '0);
	assign full  = (level == level_t'(FIFO_DEPTH));

	// Head word shows ahead of the pop
	assign rdata = mem[rd_ptr];

	always_ff @(posedge rvx_port_15)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	// **********************************************************************
	// Pointers and fill level
	// **********************************************************************
	always_ff @(posedge rvx_port_15 or negedge rvx_port_16)
	begin
		if (!rvx_port_16)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/word_counter.sv
`timescale 1ns/1ns
`default_nettype none

module word_counter import xfer_pkg::*;
(
	input  wire    rvx_port_15,
	input  wire    rvx_port_16,

	input  wire    load,
	input  level_t load_value,
	input  wire    step,

	output level_t remaining,
	output logic   zero
);

	assign zero = (remaining == '0);

	// Load wins over a step in the same cycle
	always_ff @(posedge rvx_port_15 or negedge rvx_port_16)
	begin
		if (!rvx_port_16)
			remaining <= '0;
		else if (load)
			remaining <= load_value;
		else if (step && !zero)
			remaining <= remaining - 1'b1;
	end

endmodule

`default_nettype wire

// File: design/xfer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module xfer_ctrl import xfer_pkg::*;
(
	input  wire    rvx_port_15,
	input  wire    rvx_port_16,

	input  wire    start,
	input  level_t start_count,
	input  wire    done_clear,
	input  key_t   key,
	input  word_t  tx_head,
	input  wire    tx_empty,
	input  wire    rx_full,
	input  wire    zero,

	output logic   tx_pop,
	output logic   rx_push,
	output word_t  rx_wdata,
	output logic   count_load,
	output logic   count_step,
	output logic   busy,
	output logic   done
);

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	logic        move_word;

	// One word per cycle when both FIFOs allow it, else wait
	assign move_word = (state == MOVE) & ~zero & ~tx_empty & ~rx_full;

	assign tx_pop     = move_word;
	assign rx_push    = move_word;
	assign count_step = move_word;
	assign count_load = (state == IDLE) & start;

	// Key is spread over all four bytes
	assign rx_wdata = tx_head ^ {4{key}};

	assign busy = (state != IDLE);

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE: if (start) state_nxt = MOVE;
			MOVE: if (zero) state_nxt = DONE;
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	// **********************************************************************
	// State and sticky done flag
	// **********************************************************************
	always_ff @(posedge rvx_port_15 or negedge rvx_port_16)
	begin
		if (!rvx_port_16)
		begin
			state <= IDLE;
			done  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (state == DONE)
				done <= 1'b1;
			else if (done_clear)
				done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/xfer_regs.sv
`timescale 1ns/1ns
`default_nettype none

module xfer_regs import xfer_pkg::*;
(
	input  wire    rvx_port_15,
	input  wire    rvx_port_16,

	input  wire    psel,
	input  wire    penable,
	input  wire    pwrite,
	input  addr_t  paddr,
	input  word_t  pwdata,
	output word_t  prdata,
	output logic   pready,
	output logic   pslverr,

	input  level_t tx_level,
	input  level_t rx_level,
	input  word_t  rx_head,
	input  wire    tx_full,
	input  wire    rx_empty,
	input  wire    busy,
	input  wire    done,

	output logic   tx_push,
	output word_t  tx_wdata,
	output logic   rx_pop,
	output logic   start,
	output level_t start_count,
	output logic   done_clear,
	output key_t   key
);

	logic  access;
	logic  aligned;
	logic  key_we;
	word_t status_word;

	// Access phase of a selected transfer, no wait states
	assign access  = psel & penable;
	assign aligned = (paddr[1:0] == 2'b00);
	assign pready  = 1'b1;

	assign tx_wdata    = pwdata;
	assign start_count = pwdata[13:8];

	// Busy, sticky done, tx empty, rx full
	assign status_word = {28'd0,
		(rx_level == level_t'(FIFO_DEPTH)),
		(tx_level == '0),
		done,
		busy};

	// **********************************************************************
	// Address decode, strobes and read mux
	// **********************************************************************
	always_comb
	begin
		prdata     = '0;
		pslverr    = 1'b0;
		tx_push    = 1'b0;
		rx_pop     = 1'b0;
		start      = 1'b0;
		done_clear = 1'b0;
		key_we     = 1'b0;

		if (access)
		begin
			if (!aligned)
				pslverr = 1'b1;
			else
			begin
				case (paddr)
					REG_CMD:
						if (pwrite)
						begin
							// Command is refused while a transfer runs
							if (busy)
								pslverr = 1'b1;
							else
								start = pwdata[0];
						end
					REG_STATUS:
						if (pwrite)
							done_clear = 1'b1;
						else
							prdata = status_word;
					REG_CONFIG:
						if (pwrite)
							key_we = 1'b1;
						else
							prdata = word_t'(key);
					REG_TXDATA:
						if (pwrite)
						begin
							if (tx_full)
								pslverr = 1'b1;
							else
								tx_push = 1'b1;
						end
						else
							prdata = word_t'(tx_level);
					REG_RXDATA:
						if (!pwrite)
						begin
							if (rx_empty)
								pslverr = 1'b1;
							else
							begin
								rx_pop = 1'b1;
								prdata = rx_head;
							end
						end
					REG_RXLEVEL:
						if (!pwrite)
							prdata = word_t'(rx_level);
					default:
						pslverr = 1'b1;
				endcase
			end
		end
	end

	// Key register
	always_ff @(posedge rvx_port_15 or negedge rvx_port_16)
	begin
		if (!rvx_port_16)
			key <= '0;
		else if (key_we)
			key <= pwdata[7:0];
	end

endmodule

`default_nettype wire

// File: design/xfer_top.sv
`timescale 1ns/1ns
`default_nettype none

module xfer_top import xfer_pkg::*;
(
	input  wire   rvx_port_15,
	input  wire   rvx_port_16,

	input  wire   psel,
	input  wire   penable,
	input  wire   pwrite,
	input  addr_t paddr,
	input  word_t pwdata,
	output word_t prdata,
	output wire   pready,
	output wire   pslverr
);

	// Register side
	wire    tx_push;
	word_t  tx_wdata;
	wire    rx_pop;
	wire    start;
	level_t start_count;
	wire    done_clear;
	key_t   key;

	// FIFO side
	word_t  tx_head;
	wire    tx_empty;
	wire    tx_full;
	level_t tx_level;
	word_t  rx_head;
	wire    rx_empty;
	wire    rx_full;
	level_t rx_level;

	// Controller side
	wire    tx_pop;
	wire    rx_push;
	word_t  rx_wdata;
	wire    count_load;
	wire    count_step;
	wire    zero;
	wire    busy;
	wire    done;

	// **********************************************************************
	// Bus decoder
	// **********************************************************************
	xfer_regs u_regs
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.tx_level(tx_level), .rx_level(rx_level), .rx_head(rx_head),
		.tx_full(tx_full), .rx_empty(rx_empty), .busy(busy), .done(done),
		.tx_push(tx_push), .tx_wdata(tx_wdata), .rx_pop(rx_pop),
		.start(start), .start_count(start_count),
		.done_clear(done_clear), .key(key)
	);

	// Host to controller
	word_fifo u_tx_fifo
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
		.rdata(tx_head), .empty(tx_empty), .full(tx_full), .level(tx_level)
	);

	// Controller to host
	word_fifo u_rx_fifo
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
		.rdata(rx_head), .empty(rx_empty), .full(rx_full), .level(rx_level)
	);

	word_counter u_counter
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.load(count_load), .load_value(start_count), .step(count_step),
		.remaining(), .zero(zero)
	);

	xfer_ctrl u_ctrl
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.start(start), .start_count(start_count), .done_clear(done_clear),
		.key(key), .tx_head(tx_head), .tx_empty(tx_empty), .rx_full(rx_full),
		.zero(zero), .tx_pop(tx_pop), .rx_push(rx_push), .rx_wdata(rx_wdata),
		.count_load(count_load), .count_step(count_step),
		.busy(busy), .done(done)
	);

endmodule

`default_nettype wire

// File: dv/xfer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module xfer_tb
	import xfer_pkg::*;
();

	logic   rvx_port_15;
	logic   rvx_port_16;
	logic   psel;
	logic   penable;
	logic   pwrite;
	addr_t  paddr;
	word_t  pwdata;
	word_t  prdata;
	wire    pready;
	wire    pslverr;

	// Reference model of both FIFOs, the key and the sticky done flag
	word_t  tx_q[$];
	word_t  rx_q[$];
	key_t   m_key;
	logic   m_done;

	int     errors;
	int     checks;
	int     tests;
	int     errors_at_start;

	xfer_top u_dut
	(
		.rvx_port_15(rvx_port_15), .rvx_port_16(rvx_port_16),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always #2 rvx_port_15 = ~rvx_port_15;

	// Worst case is about a quarter of this
	initial
	begin
		#200000;
		$display("Run timed out before all tests finished");
		$display("Finished with errors");
		$finish;
	end

	// **********************************************************************
	// Checking and model helpers
	// **********************************************************************
	task automatic check_value(input string sig, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
				$time, sig, got, exp);
		end
	endtask

	function automatic word_t spread_key(input key_t k);
		return {k, k, k, k};
	endfunction

	function automatic word_t idle_status();
		return {28'd0, (rx_q.size() == FIFO_DEPTH), (tx_q.size() == 0), m_done, 1'b0};
	endfunction

	task automatic model_transfer(input int count);
		repeat (count)
			rx_q.push_back(tx_q.pop_front() ^ spread_key(m_key));
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	// **********************************************************************
	// Bus driver
	// **********************************************************************
	task automatic bus_access(input logic wr, input addr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
		int waits;
		@(posedge rvx_port_15);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge rvx_port_15);
		penable <= 1'b1;
		@(negedge rvx_port_15);
		waits = 0;
		while (!pready && waits < 16)
		begin
			@(negedge rvx_port_15);
			waits++;
		end
		if (!pready)
		begin
			errors++;
			$display("Bus access at offset 0x%02h was never completed by pready", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge rvx_port_15);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_expect(input addr_t addr, input word_t data, input logic exp_err);
		word_t rdata;
		logic  err;
		bus_access(1'b1, addr, data, rdata, err);
		check_value($sformatf("pslverr write 0x%02h", addr), {31'd0, err}, {31'd0, exp_err});
	endtask

	task automatic read_expect(input addr_t addr, input word_t exp, input logic exp_err);
		word_t rdata;
		logic  err;
		bus_access(1'b0, addr, '0, rdata, err);
		check_value($sformatf("pslverr read 0x%02h", addr), {31'd0, err}, {31'd0, exp_err});
		check_value($sformatf("prdata 0x%02h", addr), rdata, exp);
	endtask

	task automatic push_word(input word_t w);
		write_expect(REG_TXDATA, w, tx_q.size() == FIFO_DEPTH);
		if (tx_q.size() < FIFO_DEPTH)
			tx_q.push_back(w);
	endtask

	task automatic pop_word();
		if (rx_q.size() == 0)
			read_expect(REG_RXDATA, '0, 1'b1);
		else
			read_expect(REG_RXDATA, rx_q.pop_front(), 1'b0);
	endtask

	task automatic start_transfer(input int count, input logic exp_err);
		write_expect(REG_CMD, {18'd0, level_t'(count), 7'd0, 1'b1}, exp_err);
	endtask

	task automatic clear_done();
		write_expect(REG_STATUS, '0, 1'b0);
		m_done = 1'b0;
	endtask

	task automatic wait_done();
		word_t status;
		logic  err;
		int    polls;
		polls = 0;
		status = '0;
		while (!status[1] && polls < 100)
		begin
			bus_access(1'b0, REG_STATUS, '0, status, err);
			polls++;
		end
		if (!status[1])
		begin
			errors++;
			$display("Transfer did not report done within 100 status polls");
		end
		m_done = 1'b1;
		check_value("status.busy", {31'd0, status[0]}, '0);
	endtask

	// **********************************************************************
	// Test sequence
	// **********************************************************************
	initial
	begin
		word_t rdata;
		logic  err;
		int    count;

		rvx_port_15 = 1'b0;
		rvx_port_16 = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		errors_at_start = 0;
		m_key   = '0;
		m_done  = 1'b0;
		count   = $urandom(32'h6d83);

		repeat (3) @(posedge rvx_port_15);
		rvx_port_16 <= 1'b1;

		// Reset values, then key readback
		read_expect(REG_CONFIG, '0, 1'b0);
		read_expect(REG_STATUS, idle_status(), 1'b0);
		repeat (8)
		begin
			m_key = key_t'($urandom);
			write_expect(REG_CONFIG, {24'($urandom), m_key}, 1'b0);
			read_expect(REG_CONFIG, word_t'(m_key), 1'b0);
		end
		finish_test("config register");

		// Fill the transmit FIFO and push once beyond it
		repeat (FIFO_DEPTH)
		begin
			push_word($urandom);
			read_expect(REG_TXDATA, word_t'(tx_q.size()), 1'b0);
		end
		push_word($urandom);
		read_expect(REG_TXDATA, word_t'(FIFO_DEPTH), 1'b0);
		finish_test("transmit fifo");

		repeat (4)
		begin
			m_key = key_t'($urandom);
			write_expect(REG_CONFIG, word_t'(m_key), 1'b0);
			if (tx_q.size() < 4)
				repeat ($urandom_range(4, 12)) push_word($urandom);
			count = $urandom_range(1, tx_q.size());
			start_transfer(count, 1'b0);
			model_transfer(count);
			wait_done();
			read_expect(REG_RXLEVEL, word_t'(count), 1'b0);
			while (rx_q.size() > 0)
				pop_word();
			clear_done();
			read_expect(REG_STATUS, idle_status(), 1'b0);
		end
		finish_test("transfer");

		// Leave four free entries in the receive FIFO, then overrun them
		while (tx_q.size() < FIFO_DEPTH)
			push_word($urandom);
		start_transfer(FIFO_DEPTH - 4, 1'b0);
		model_transfer(FIFO_DEPTH - 4);
		wait_done();
		clear_done();
		repeat (8) push_word($urandom);
		start_transfer(12, 1'b0);
		model_transfer(12);
		repeat (2)
		begin
			bus_access(1'b0, REG_STATUS, '0, rdata, err);
			check_value("status.busy_done", rdata & 32'h3, 32'h1);
		end
		read_expect(REG_RXLEVEL, word_t'(FIFO_DEPTH), 1'b0);
		// Receive FIFO full, eight words still waiting on the transmit side
		read_expect(REG_STATUS, {28'd0, 1'b1, 1'b0, 1'b0, 1'b1}, 1'b0);
		repeat (10) pop_word();
		wait_done();
		read_expect(REG_RXLEVEL, word_t'(rx_q.size()), 1'b0);
		while (rx_q.size() > 0)
			pop_word();
		clear_done();
		read_expect(REG_STATUS, idle_status(), 1'b0);
		finish_test("back-pressure");

		// Misaligned and unmapped offsets leave all state alone
		write_expect(5'h01, 32'h0000_0401, 1'b1);
		write_expect(5'h09, 32'h0000_00a5, 1'b1);
		read_expect(5'h06, '0, 1'b1);
		read_expect(5'h13, '0, 1'b1);
		write_expect(5'h18, 32'hffff_ffff, 1'b1);
		read_expect(5'h1C, '0, 1'b1);
		read_expect(REG_CONFIG, word_t'(m_key), 1'b0);
		read_expect(REG_STATUS, idle_status(), 1'b0);
		pop_word();
		count = tx_q.size() + 2;
		start_transfer(count, 1'b0);
		bus_access(1'b0, REG_STATUS, '0, rdata, err);
		check_value("status.busy", {31'd0, rdata[0]}, 32'h1);
		start_transfer(1, 1'b1);
		repeat (2) push_word($urandom);
		model_transfer(count);
		wait_done();
		read_expect(REG_RXLEVEL, word_t'(count), 1'b0);
		while (rx_q.size() > 0)
			pop_word();
		clear_done();
		read_expect(REG_STATUS, idle_status(), 1'b0);
		finish_test("errors");

		// A zero count completes without touching the FIFOs
		repeat (3) push_word($urandom);
		start_transfer(0, 1'b0);
		wait_done();
		read_expect(REG_STATUS, idle_status(), 1'b0);
		clear_done();
		read_expect(REG_STATUS, idle_status(), 1'b0);
		start_transfer(0, 1'b0);
		wait_done();
		read_expect(REG_TXDATA, word_t'(3), 1'b0);
		read_expect(REG_RXLEVEL, '0, 1'b0);
		read_expect(REG_STATUS, idle_status(), 1'b0);
		finish_test("done clear");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
design/xfer_pkg.sv
design/word_fifo.sv
design/word_counter.sv
design/xfer_ctrl.sv
design/xfer_regs.sv
design/xfer_top.sv
dv/xfer_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the transfer peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module xfer_tb -o xfer_sim

sim_out=$(./obj_dir/xfer_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "^Finished with no errors$"; then
	exit 0
fi
exit 1
